/* verilog/single_cpu_config.svh */
`ifndef SINGLE_CPU_CONFIG_SVH
`define SINGLE_CPU_CONFIG_SVH

`default_nettype none

// Datapath and address width
`define XLEN 32

// Memory depths in words
`define IMEM_WORDS 256
`define DMEM_WORDS 64

`define RESET_PC 32'h0000_0000 // First fetch address

`default_nettype wire

`endif

/* verilog/single_cpu_pkg.sv */
`include "single_cpu_config.svh"

`default_nettype none

package single_cpu_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011, // Register-register ALU
        OP_IMM = 7'b0010011, // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // The three instruction formats the core decodes
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        opcode_e    opcode;
    } inst_s_t;

    typedef union packed {
        inst_r_t     r;
        inst_i_t     i;
        inst_s_t     s;
        logic [31:0] raw;
    } inst_u;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              use_imm;   // Operand b from imm
        logic              rd_we;
        logic              mem_we;
        logic              mem_to_rd; // Write back load data
        logic [`XLEN-1:0]  imm;
    } ctrl_t;

    typedef struct packed {
        logic                            we;
        logic [$clog2(`IMEM_WORDS)-1:0]  addr; // Word index
        logic [`XLEN-1:0]                data;
    } prog_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [31:0]       inst;
        logic [4:0]        rd;
        logic              rd_we;
        logic [`XLEN-1:0]  wb_data;
    } retire_t;

endpackage

`default_nettype wire

/* verilog/inst_mem.sv */
`include "single_cpu_config.svh"

`default_nettype none

module inst_mem (
    input  wire logic                            CLK,
    input  wire single_cpu_pkg::prog_t           prog,
    input  wire logic [$clog2(`IMEM_WORDS)-1:0]  fetch_index,
    output single_cpu_pkg::inst_u                inst
);

    logic [31:0] mem [`IMEM_WORDS]; // Program storage

    // Host load path, only used while the core is stopped
    always_ff @(posedge CLK) begin
        if (prog.we) begin
            mem[prog.addr] <= prog.data;
        end
    end

    assign inst.raw = mem[fetch_index]; // Async fetch

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`include "single_cpu_config.svh"

`default_nettype none

module register_file (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic [4:0]        rs1,
    input  wire logic [4:0]        rs2,
    input  wire logic [4:0]        rd,
    input  wire logic              we,
    input  wire logic [`XLEN-1:0]  wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    localparam int NREGS = 32;

    logic [`XLEN-1:0] regs [NREGS];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int k = 0; k < NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // Old value visible during the write cycle
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`include "single_cpu_config.svh"

`default_nettype none

module decoder (
    input  wire single_cpu_pkg::inst_u  inst,
    output single_cpu_pkg::ctrl_t       ctrl
);

    import single_cpu_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_sh;
    logic             shift_f3;

    // funct3 to operation, alt picks SUB or SRA
    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign imm_i  = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_s  = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst.i.imm[4:0]}; // shamt only

    // SLLI, SRLI and SRAI
    assign shift_f3 = (inst.i.funct3 == 3'b001) || (inst.i.funct3 == 3'b101);

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ADD;
        case (inst.r.opcode)
            OP: begin
                ctrl.alu_op = alu_sel(inst.r.funct3, inst.r.funct7[5]);
                ctrl.rd_we  = 1'b1;
            end
            OP_IMM: begin
                // imm[10] only matters for the right shift
                ctrl.alu_op  = alu_sel(inst.i.funct3,
                                       inst.i.funct3 == 3'b101 && inst.i.imm[10]);
                ctrl.use_imm = 1'b1;
                ctrl.rd_we   = 1'b1;
                ctrl.imm     = shift_f3 ? imm_sh : imm_i;
            end
            LOAD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.rd_we     = 1'b1;
                ctrl.mem_to_rd = 1'b1;
                ctrl.imm       = imm_i;
            end
            STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
                ctrl.imm     = imm_s;
            end
            default: begin
                ctrl.rd_we  = 1'b0; // Unsupported opcode, retire as no-op
                ctrl.mem_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`include "single_cpu_config.svh"

`default_nettype none

module alu (
    input  wire single_cpu_pkg::alu_op_e  op,
    input  wire logic [`XLEN-1:0]         a,
    input  wire logic [`XLEN-1:0]         b,
    output logic [`XLEN-1:0]              y
);

    import single_cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only low five bits shift

    always_comb begin
        case (op)
            ADD:  y = a + b;
            SUB:  y = a - b;
            SLL:  y = a << shamt;
            SLT:  y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU: y = {{(`XLEN-1){1'b0}}, a < b};
            XOR:  y = a ^ b;
            SRL:  y = a >> shamt;
            SRA:  y = $unsigned($signed(a) >>> shamt); // Sign fill
            OR:   y = a | b;
            AND:  y = a & b;
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/data_mem.sv */
`include "single_cpu_config.svh"

`default_nettype none

module data_mem (
    input  wire logic                            CLK,
    input  wire logic                            RST,
    input  wire logic [$clog2(`DMEM_WORDS)-1:0]  index,
    input  wire logic                            we,
    input  wire logic [`XLEN-1:0]                wd,
    output logic [`XLEN-1:0]                     rd
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    // Contents start at zero so loads before stores are defined
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int k = 0; k < `DMEM_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else if (we) begin
            mem[index] <= wd;
        end
    end

    assign rd = mem[index]; // Async read

endmodule

`default_nettype wire

/* verilog/single_cpu.sv */
`include "single_cpu_config.svh"

`default_nettype none

module single_cpu (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    run,
    input  wire single_cpu_pkg::prog_t   prog,
    output single_cpu_pkg::retire_t      retire
);

    import single_cpu_pkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);
    localparam logic [`XLEN-1:0] PC_LIMIT = `XLEN'(`IMEM_WORDS * 4);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_inc;
    logic [`XLEN-1:0] pc_next;
    inst_u            inst;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;
    logic [`XLEN-1:0] mem_rd;
    logic [`XLEN-1:0] wb_data;

    assign pc_inc  = pc + `XLEN'(4);
    assign pc_next = (pc_inc == PC_LIMIT) ? '0 : pc_inc; // Wrap at end of program

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= `RESET_PC;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    inst_mem u_inst_mem (
        .CLK         (CLK),
        .prog        (prog),
        .fetch_index (pc[IMEM_AW+1:2]),
        .inst        (inst)
    );

    decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    register_file u_register_file (
        .CLK (CLK),
        .RST (RST),
        .rs1 (inst.r.rs1),
        .rs2 (inst.r.rs2),
        .rd  (inst.r.rd),
        .we  (ctrl.rd_we & run), // No writes while stopped
        .wd  (wb_data),
        .rd1 (rs1_val),
        .rd2 (rs2_val)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_val;

    alu u_alu (
        .op (ctrl.alu_op),
        .a  (rs1_val),
        .b  (alu_b),
        .y  (alu_y)
    );

    data_mem u_data_mem (
        .CLK   (CLK),
        .RST   (RST),
        .index (alu_y[DMEM_AW+1:2]), // Word address
        .we    (ctrl.mem_we & run),
        .wd    (rs2_val),
        .rd    (mem_rd)
    );

    assign wb_data = ctrl.mem_to_rd ? mem_rd : alu_y;

    // One record per executed instruction, a cycle after it commits
    always_ff @(posedge CLK) begin
        if (RST) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= run;
            if (run) begin
                retire.pc      <= pc;
                retire.inst    <= inst.raw;
                retire.rd      <= inst.r.rd;
                retire.rd_we   <= ctrl.rd_we;
                retire.wb_data <= wb_data; // Reported even for x0
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    input  wire logic rst_req, // Extra reset pulse between tests
    output logic      CLK,
    output logic      RST
);

    timeunit 1ns;
    timeprecision 100ps;

    logic por; // Power-on reset

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK; // 20 ns period
    end

    initial begin
        por = 1'b1;
        repeat (3) @(posedge CLK); // Three rising edges in reset
        @(negedge CLK);
        por = 1'b0;
    end

    assign RST = por | rst_req;

endmodule

`default_nettype wire

/* test/tb_single_cpu.sv */
`default_nettype none

module tb_single_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    import single_cpu_pkg::*;

    localparam int NWORDS = 64; // Program length and data words
    localparam int NTESTS = 5;

    logic        CLK;
    logic        RST;
    logic        rst_req;
    logic        run;
    prog_t       prog;
    retire_t     retire;
    inst_u       program_m [NWORDS];
    logic [31:0] regs_m [32];     // Reference register file
    logic [31:0] dmem_m [NWORDS]; // Reference data memory
    logic [7:0]  last_off;
    int          errors;
    int          tests;
    bit          timed_out;
    string       test_name [NTESTS] = '{"op_group", "op_imm", "rd_zero", "load_store",
                                        "unknown_opcode"};

    tb_clock_gen u_clock_gen (
        .rst_req (rst_req),
        .CLK     (CLK),
        .RST     (RST)
    );

    single_cpu uut (
        .CLK    (CLK),
        .RST    (RST),
        .run    (run),
        .prog   (prog),
        .retire (retire)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)}; // Signs differ
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return 32'({{32{a[31]}}, a} >> b[4:0]); // Sign-extended word
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Random instruction of the kind each test exercises
    function automatic inst_u gen_word(input int kind, input int idx);
        inst_u      w;
        int         form;
        logic [7:0] off;
        w.raw = $urandom;
        off = {w.raw[25:20], 2'b00}; // Random aligned word offset
        form = kind;
        if (kind == 2) form = idx % 2;
        if (kind == 4) form = (idx % 3 == 0) ? 3 : ((idx % 3 == 1) ? 4 : 1);
        if (idx < 8) begin
            w.i.opcode = OP_IMM; // ADDI seeds x1..x8
            w.i.funct3 = 3'b000;
            w.i.rs1    = 5'd0;
            w.i.rd     = 5'(idx + 1);
            if (kind == 1) w.i.imm[11] = 1'b1;
            return w;
        end
        case (form)
            0: begin
                w.r.opcode = OP;
                w.r.funct7 = {1'b0, w.r.funct7[5] & (w.r.funct3 == 3'd0 ||
                              w.r.funct3 == 3'd5), 5'd0};
            end
            1: begin
                w.i.opcode = OP_IMM;
                if (w.i.funct3 == 3'd1) w.i.imm[11:5] = 7'd0;
                if (w.i.funct3 == 3'd5) w.i.imm[11:5] = {1'b0, w.i.imm[10], 5'd0};
            end
            3: begin
                if (idx % 2 == 1 && w.raw[31]) off = last_off; // Load right after store
                last_off = off;
                if (idx % 2 == 0) begin
                    w.s.opcode = STORE;
                    w.s.imm_hi = {4'd0, off[7:5]};
                    w.s.imm_lo = off[4:0];
                end else begin
                    w.i.opcode = LOAD;
                    w.i.imm    = {4'd0, off};
                end
                w.r.rs1    = 5'd0;
                w.r.funct3 = 3'b010;
            end
            default: begin
                while (w.raw[6:0] inside {OP, OP_IMM, LOAD, STORE}) w.raw = $urandom;
            end
        endcase
        if (kind == 2 && idx % 3 == 0) w.r.rd = 5'd0;
        if (kind == 2 && idx % 5 == 0) w.r.rs1 = 5'd0;
        return w;
    endfunction

    task automatic model_step(input inst_u w, output logic we, output logic [31:0] wb);
        logic [31:0] a;
        logic [31:0] addr;
        a  = regs_m[w.r.rs1];
        we = 1'b1;
        wb = 32'd0;
        case (w.r.opcode)
            OP:     wb = ref_alu(w.r.funct3, w.r.funct7[5], a, regs_m[w.r.rs2]);
            OP_IMM: wb = ref_alu(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm[10], a,
                                 sext12(w.i.imm));
            LOAD: begin
                addr = a + sext12(w.i.imm);
                wb   = dmem_m[addr[7:2]];
            end
            STORE: begin
                we   = 1'b0;
                addr = a + sext12({w.s.imm_hi, w.s.imm_lo});
                dmem_m[addr[7:2]] = regs_m[w.s.rs2];
            end
            default: we = 1'b0; // Outside the kept set
        endcase
        if (we && w.r.rd != 5'd0) regs_m[w.r.rd] = wb;
    endtask

    task automatic pulse_reset();
        int n;
        n = 0;
        @(negedge CLK);
        rst_req = 1'b1;
        repeat (3) @(negedge CLK);
        rst_req = 1'b0;
        while (RST && n < 20) begin
            @(negedge CLK);
            n++;
        end
        if (RST) begin
            $display("Timeout: reset never released");
            timed_out = 1'b1;
        end
        for (int k = 0; k < 32; k++) regs_m[k] = 32'd0;
        for (int k = 0; k < NWORDS; k++) dmem_m[k] = 32'd0;
    endtask

    task automatic load_program(input int kind);
        for (int i = 0; i < NWORDS; i++) begin
            program_m[i] = gen_word(kind, i);
            @(negedge CLK);
            check_value("retire.valid", 32'(retire.valid), 32'd0); // Idle while stopped
            prog.we   = 1'b1;
            prog.addr = 8'(i);
            prog.data = program_m[i].raw;
        end
    endtask

    task automatic run_program();
        int          got;
        int          issued;
        int          cycles;
        logic        exp_we;
        logic [31:0] exp_wb;
        got    = 0;
        issued = 0;
        cycles = 0;
        @(negedge CLK);
        prog.we = 1'b0;
        run     = 1'b1;
        while (got < NWORDS && cycles < 200) begin
            @(negedge CLK);
            cycles++;
            if (run) begin
                issued++;
                if (issued == NWORDS) run = 1'b0; // Last instruction already issued
            end
            if (retire.valid) begin
                model_step(program_m[got], exp_we, exp_wb);
                check_value("retire.pc", retire.pc, 32'(got * 4));
                check_value("retire.inst", retire.inst, program_m[got].raw);
                check_value("retire.rd", 32'(retire.rd), 32'(program_m[got].r.rd));
                check_value("retire.rd_we", 32'(retire.rd_we), 32'(exp_we));
                if (exp_we) check_value("retire.wb_data", retire.wb_data, exp_wb);
                got++;
            end
        end
        run = 1'b0;
        if (got < NWORDS) begin
            $display("Timeout: only %0d of %0d retire records arrived", got, NWORDS);
            timed_out = 1'b1;
        end
        @(negedge CLK);
        check_value("retire.valid", 32'(retire.valid), 32'd0); // No extra record
    endtask

    initial begin
        int start_err;
        void'($urandom(32'h0a220318));
        rst_req   = 1'b0;
        run       = 1'b0;
        prog      = '0;
        errors    = 0;
        tests     = 0;
        timed_out = 1'b0;
        last_off  = 8'd0;
        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            start_err = errors;
            pulse_reset();
            if (!timed_out) begin
                load_program(t);
                run_program();
            end
            tests++;
            $display("Test %0d %s done with %0d errors", t, test_name[t], errors - start_err);
        end
        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/single_cpu_pkg.sv
verilog/inst_mem.sv
verilog/register_file.sv
verilog/decoder.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/single_cpu.sv
test/tb_clock_gen.sv
test/tb_single_cpu.sv

/* Makefile */
TOP := tb_single_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
